// ==== design/fpu_addsub_pkg.sv ====
package fpu_addsub_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    // Significand with the hidden one
    localparam int SIG_W    = FRAC_W + 1;
    localparam int GUARD_W  = 4;
    localparam int EXT_W    = SIG_W + GUARD_W;
    // Leading-one index into the upper SIG_W bits
    localparam int LOPD_W   = 5;
    // Input strobe to output strobe
    localparam int PIPE_LAT = 3;

    typedef enum logic {
        FPU_ADD = 1'b0,
        FPU_SUB = 1'b1
    } fpu_op_e;

    //////////////////////////////
    // Operand and stage types
    //////////////////////////////
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp32_t;

    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exp;
        logic [SIG_W-1:0] sig;
    } fpu_fields_t;

    // Stage one register
    typedef struct packed {
        fpu_op_e     op;
        fpu_fields_t a;
        fpu_fields_t b;
    } fpu_operands_t;

    // Big is the operand with the larger exponent
    typedef struct packed {
        fpu_op_e          op;
        logic             sign_big;
        logic             sign_small;
        logic [EXP_W-1:0] exp_big;
        logic [EXT_W-1:0] sig_big;
        logic [EXT_W-1:0] sig_small;
    } fpu_aligned_t;

    // Stage two register
    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exp_big;
        logic [EXT_W-1:0] sum;
        logic             carry;
    } fpu_sum_t;

endpackage

// ==== design/fpu_addsub_top.sv ====
`timescale 1ns/1ns

module fpu_addsub_top (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_valid,
    input  fpu_addsub_pkg::fpu_op_e i_op,
    input  fpu_addsub_pkg::fp32_t   i_a,
    input  fpu_addsub_pkg::fp32_t   i_b,
    output logic                    o_valid,
    output fpu_addsub_pkg::fp32_t   o_result
);

    import fpu_addsub_pkg::*;

    logic          s1_valid;
    fpu_operands_t s1_ops;
    fpu_aligned_t  aligned;
    logic          s2_valid;
    fpu_sum_t      s2_sum;
    fp32_t         norm_word;

    //////////////////////////////
    // Stage one
    //////////////////////////////
    fpu_operand_unpack u_unpack (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_op    (i_op),
        .i_a     (i_a),
        .i_b     (i_b),
        .o_valid (s1_valid),
        .o_ops   (s1_ops)
    );

    //////////////////////////////
    // Stage two
    //////////////////////////////
    fpu_exp_align u_align (
        .i_ops     (s1_ops),
        .o_aligned (aligned)
    );

    fpu_man_alu u_alu (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (s1_valid),
        .i_aligned (aligned),
        .o_valid   (s2_valid),
        .o_sum     (s2_sum)
    );

    //////////////////////////////
    // Stage three
    //////////////////////////////
    fpu_normalize u_norm (
        .i_sum  (s2_sum),
        .o_word (norm_word)
    );

    fpu_result_pack u_pack (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (s2_valid),
        .i_word   (norm_word),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

endmodule

// ==== design/fpu_exp_align.sv ====
`timescale 1ns/1ns

module fpu_exp_align (
    input  fpu_addsub_pkg::fpu_operands_t i_ops,
    output fpu_addsub_pkg::fpu_aligned_t  o_aligned
);

    import fpu_addsub_pkg::*;

    // B with its sign flipped for subtraction
    fpu_fields_t      b_eff;
    fpu_fields_t      op_big;
    fpu_fields_t      op_small;
    logic             a_less;
    logic [EXP_W-1:0] exp_diff;
    logic [EXT_W-1:0] sig_big_ext;
    logic [EXT_W-1:0] sig_small_ext;
    logic [EXT_W-1:0] sig_small_shf;

    //////////////////////////////
    // Effective operation
    //////////////////////////////
    // a - b becomes a + (-b), so the ALU only adds signed magnitudes
    always_comb begin
        b_eff = i_ops.b;
        if (i_ops.op == FPU_SUB) begin
            b_eff.sign = ~i_ops.b.sign;
        end
    end

    //////////////////////////////
    // Exponent compare and swap
    //////////////////////////////
    // Equal exponents keep a as the big operand
    assign a_less = (i_ops.a.exp < b_eff.exp);

    always_comb begin
        if (a_less) begin
            op_big   = b_eff;
            op_small = i_ops.a;
        end else begin
            op_big   = i_ops.a;
            op_small = b_eff;
        end
    end

    // Never negative after the swap
    assign exp_diff = op_big.exp - op_small.exp;

    //////////////////////////////
    // Significand alignment
    //////////////////////////////
    assign sig_big_ext   = {op_big.sig, {GUARD_W{1'b0}}};
    assign sig_small_ext = {op_small.sig, {GUARD_W{1'b0}}};

    // Truncating shift, no sticky bit
    // A gap of EXT_W or more leaves nothing of the small operand
    always_comb begin
        if (exp_diff >= EXP_W'(EXT_W)) begin
            sig_small_shf = '0;
        end else begin
            sig_small_shf = sig_small_ext >> exp_diff;
        end
    end

    always_comb begin
        o_aligned.op         = i_ops.op;
        o_aligned.sign_big   = op_big.sign;
        o_aligned.sign_small = op_small.sign;
        o_aligned.exp_big    = op_big.exp;
        o_aligned.sig_big    = sig_big_ext;
        o_aligned.sig_small  = sig_small_shf;
    end

endmodule

// ==== design/fpu_man_alu.sv ====
`timescale 1ns/1ns

module fpu_man_alu (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_valid,
    input  fpu_addsub_pkg::fpu_aligned_t i_aligned,
    output logic                         o_valid,
    output fpu_addsub_pkg::fpu_sum_t     o_sum
);

    import fpu_addsub_pkg::*;

    logic             same_sign;
    logic             small_gt;
    logic [EXT_W-1:0] mag_hi;
    logic [EXT_W-1:0] mag_lo;
    logic [EXT_W:0]   result;
    fpu_sum_t         sum_d;

    assign same_sign = (i_aligned.sign_big == i_aligned.sign_small);
    // Equal exponents can still leave the small operand larger
    assign small_gt  = (i_aligned.sig_small > i_aligned.sig_big);
    assign mag_hi    = small_gt ? i_aligned.sig_small : i_aligned.sig_big;
    assign mag_lo    = small_gt ? i_aligned.sig_big   : i_aligned.sig_small;

    //////////////////////////////
    // Magnitude add / subtract
    //////////////////////////////
    always_comb begin
        if (same_sign) begin
            result     = {1'b0, mag_hi} + {1'b0, mag_lo};
            sum_d.sign = i_aligned.sign_big;
        end else begin
            result     = {1'b0, mag_hi} - {1'b0, mag_lo};
            sum_d.sign = small_gt ? i_aligned.sign_small : i_aligned.sign_big;
            // Exact cancellation is +0
            if (result == '0) begin
                sum_d.sign = 1'b0;
            end
        end
        sum_d.exp_big = i_aligned.exp_big;
        sum_d.sum     = result[EXT_W-1:0];
        sum_d.carry   = result[EXT_W];
    end

    //////////////////////////////
    // Stage two registers
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_sum <= sum_d;
        end
    end

    // Larger minus smaller fits, so a registered difference has no carry
    a_diff_no_carry : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_valid && !same_sign) |=> !o_sum.carry
    ) else $error("carry out of a magnitude difference");

endmodule

// ==== design/fpu_normalize.sv ====
`timescale 1ns/1ns

module fpu_normalize (
    input  fpu_addsub_pkg::fpu_sum_t i_sum,
    output fpu_addsub_pkg::fp32_t    o_word
);

    import fpu_addsub_pkg::*;

    logic [SIG_W-1:0]  lead_bits;
    logic [LOPD_W-1:0] lead_pos;
    logic              lead_zero;
    logic [LOPD_W-1:0] shift_left;
    logic              is_zero;
    logic [EXT_W-1:0]  sig_norm;
    // Two spare bits so a wrapped exponent is visible
    logic [EXP_W+1:0]  exp_wide;

    //////////////////////////////
    // Leading-one detector
    //////////////////////////////
    // Only the upper SIG_W bits count, guard bits alone read as zero
    assign lead_bits = i_sum.sum[EXT_W-1:GUARD_W];
    assign lead_zero = (lead_bits == '0);

    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < SIG_W; i++) begin
            if (lead_bits[i]) begin
                lead_pos = i[LOPD_W-1:0];
            end
        end
    end

    // Distance from the top set bit to the hidden position
    assign shift_left = LOPD_W'(SIG_W - 1) - lead_pos;

    // A carry always leaves a nonzero value, even with an empty sum field
    assign is_zero = !i_sum.carry && lead_zero;

    //////////////////////////////
    // Shift and exponent adjust
    //////////////////////////////
    always_comb begin
        if (i_sum.carry) begin
            sig_norm = {1'b1, i_sum.sum[EXT_W-1:1]};
            exp_wide = {2'b00, i_sum.exp_big} + 1'b1;
        end else if (is_zero) begin
            sig_norm = '0;
            exp_wide = '0;
        end else begin
            sig_norm = i_sum.sum << shift_left;
            exp_wide = {2'b00, i_sum.exp_big} - {{(EXP_W+2-LOPD_W){1'b0}}, shift_left};
        end
    end

    // Fraction is truncated, the guard bits drop off here
    always_comb begin
        o_word.sign = i_sum.sign;
        o_word.exp  = exp_wide[EXP_W-1:0];
        o_word.frac = sig_norm[EXT_W-2:GUARD_W];
    end

    // Overflow and underflow of the result exponent are not handled
    always_comb begin
        if (!is_zero) begin
            a_exp_in_range : assert final (
                (exp_wide >= (EXP_W+2)'(1)) && (exp_wide <= (EXP_W+2)'(254))
            ) else $error("result exponent out of range: %0d", exp_wide);
        end
    end

endmodule

// ==== design/fpu_operand_unpack.sv ====
`timescale 1ns/1ns

module fpu_operand_unpack (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_valid,
    input  fpu_addsub_pkg::fpu_op_e       i_op,
    input  fpu_addsub_pkg::fp32_t         i_a,
    input  fpu_addsub_pkg::fp32_t         i_b,
    output logic                          o_valid,
    output fpu_addsub_pkg::fpu_operands_t o_ops
);

    import fpu_addsub_pkg::*;

    fpu_operands_t ops_d;

    // Split a word into fields, hidden one in front of the fraction
    function automatic fpu_fields_t unpack_word(input fp32_t word);
        fpu_fields_t fields;
        fields.sign = word.sign;
        fields.exp  = word.exp;
        fields.sig  = {1'b1, word.frac};
        return fields;
    endfunction

    always_comb begin
        ops_d.op = i_op;
        ops_d.a  = unpack_word(i_a);
        ops_d.b  = unpack_word(i_b);
    end

    //////////////////////////////
    // Stage one registers
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Payload holds between strobes
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_ops <= ops_d;
        end
    end

    // Only normal operands are handled
    // (zero, subnormal, infinity and NaN are outside the datapath)
    a_normal_operands : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> (i_a.exp != '0) && (i_a.exp != '1) &&
                    (i_b.exp != '0) && (i_b.exp != '1)
    ) else $error("non-normal operand exponent a=%h b=%h", i_a.exp, i_b.exp);

endmodule

// ==== design/fpu_result_pack.sv ====
`timescale 1ns/1ns

module fpu_result_pack (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  fpu_addsub_pkg::fp32_t i_word,
    output logic                  o_valid,
    output fpu_addsub_pkg::fp32_t o_result
);

    import fpu_addsub_pkg::*;

    logic  is_zero;
    fp32_t word_out;

    // Zero always leaves as +0
    assign is_zero = (i_word.exp == '0) && (i_word.frac == '0);

    always_comb begin
        word_out      = i_word;
        word_out.sign = i_word.sign && !is_zero;
    end

    //////////////////////////////
    // Output registers
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid  <= 1'b0;
            o_result <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_result <= word_out;
            end
        end
    end

    // Strobe must be clean at the boundary, whatever the stages did
    a_valid_known : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(o_valid)
    ) else $error("o_valid is unknown");

endmodule

// ==== fpu_addsub_top.f ====
+incdir+tests
design/fpu_addsub_pkg.sv
design/fpu_operand_unpack.sv
design/fpu_exp_align.sv
design/fpu_man_alu.sv
design/fpu_normalize.sv
design/fpu_result_pack.sv
design/fpu_addsub_top.sv
tests/tb_fpu_addsub_top.sv

// ==== tests/fpu_addsub_vectors.svh ====
`ifndef FPU_ADDSUB_VECTORS_SVH
`define FPU_ADDSUB_VECTORS_SVH

// Each row holds op, operand a, operand b and the expected result
// Words are IEEE-754 single precision in hex
typedef struct packed {
    fpu_op_e op;
    fp32_t   a;
    fp32_t   b;
    fp32_t   result;
} vector_t;

localparam int NUM_VECTORS = 25;

localparam vector_t VECTORS [NUM_VECTORS] = '{
    // Addition with a carry that raises the exponent
    '{FPU_ADD, 32'h3FC00000, 32'h3FC00000, 32'h40400000},
    '{FPU_ADD, 32'h3F800000, 32'h3F800000, 32'h40000000},
    '{FPU_ADD, 32'h3F800000, 32'h40000000, 32'h40400000},
    '{FPU_ADD, 32'h3F800000, 32'h3F000000, 32'h3FC00000},
    '{FPU_ADD, 32'h3FE00000, 32'h3F000000, 32'h40100000},
    '{FPU_ADD, 32'hBF800000, 32'hC0400000, 32'hC0800000},
    // Low bit lost by truncation after the carry shift
    '{FPU_ADD, 32'h3F800000, 32'h3F800001, 32'h40000000},
    // Partial cancellation
    '{FPU_SUB, 32'h3F800000, 32'h3F400000, 32'h3E800000},
    '{FPU_SUB, 32'h3F800000, 32'h40000000, 32'hBF800000},
    '{FPU_SUB, 32'h40200000, 32'h40800000, 32'hBFC00000},
    '{FPU_SUB, 32'h3FA00000, 32'h3FC00000, 32'hBE800000},
    '{FPU_ADD, 32'h3F400000, 32'hBF800000, 32'hBE800000},
    '{FPU_SUB, 32'hBF800000, 32'hC0400000, 32'h40000000},
    '{FPU_SUB, 32'h3F800001, 32'h3F800000, 32'h34000000},
    // Exact cancellation is +0
    '{FPU_SUB, 32'h40400000, 32'h40400000, 32'h00000000},
    '{FPU_ADD, 32'h3FC00000, 32'hBFC00000, 32'h00000000},
    '{FPU_SUB, 32'hC0000000, 32'hC0000000, 32'h00000000},
    // Negative difference left only in the guard bits still leaves as +0
    '{FPU_SUB, 32'hBF800000, 32'hBF7FFFFF, 32'h00000000},
    // Gaps of 28 and more
    '{FPU_ADD, 32'h3F800000, 32'h31800000, 32'h3F800000},
    '{FPU_SUB, 32'h3F800000, 32'h30800000, 32'h3F800000},
    '{FPU_ADD, 32'h31800000, 32'h3F800000, 32'h3F800000},
    // Gaps of 24 and 27 touch only the guard bits
    '{FPU_ADD, 32'h3F800000, 32'h33FFFFFF, 32'h3F800000},
    '{FPU_SUB, 32'h3F800000, 32'h33FFFFFF, 32'h3F7FFFFE},
    '{FPU_ADD, 32'h3F800000, 32'h327FFFFF, 32'h3F800000},
    '{FPU_SUB, 32'h3F800000, 32'h327FFFFF, 32'h3F7FFFFF}
};

`endif

// ==== tests/tb_fpu_addsub_top.sv ====
`timescale 1ns/1ns

module tb_fpu_addsub_top;

    import fpu_addsub_pkg::*;

    `include "fpu_addsub_vectors.svh"

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 200;
    // Two cycles per table entry and one per random operation plus slack
    localparam int RUN_CYCLES   = RESET_CYCLES + 2 * NUM_VECTORS + NUM_RANDOM + 20;

    logic    clk;
    logic    rst_n;
    logic    i_valid;
    fpu_op_e i_op;
    fp32_t   i_a;
    fp32_t   i_b;
    logic    o_valid;
    fp32_t   o_result;

    // Results still to come out with the oldest first
    fp32_t               expected_q[$];
    // Input strobes of the last PIPE_LAT cycles
    logic [PIPE_LAT-1:0] valid_hist;
    int                  results_seen = 0;

    fpu_addsub_top fpu_addsub_top_i (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_valid  (i_valid),
        .i_op     (i_op),
        .i_a      (i_a),
        .i_b      (i_b),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Failure and compare tasks
    //////////////////////////////
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_result(input string name, input fp32_t actual, input fp32_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0t ns: %s = %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    task automatic check_valid(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0t ns: %s = %b, expected %b",
                                $time, name, actual, expected));
        end
    endtask

    //////////////////////////////
    // Reference arithmetic
    //////////////////////////////
    // Four guard bits with truncating align and result and no sticky bit
    function automatic fp32_t reference_addsub(input fpu_op_e op, input fp32_t a,
                                               input fp32_t b);
        logic        sign_x;
        logic        sign_y;
        logic        sign_r;
        int          exp_x;
        int          exp_y;
        int          exp_r;
        int          gap;
        logic [31:0] mag_x;
        logic [31:0] mag_y;
        logic [31:0] mag;
        fp32_t       res;
        // Subtraction adds b with its sign turned over
        sign_x = a.sign;
        sign_y = b.sign ^ (op == FPU_SUB);
        exp_x  = a.exp;
        exp_y  = b.exp;
        mag_x  = {8'b0, 1'b1, a.frac} << GUARD_W;
        mag_y  = {8'b0, 1'b1, b.frac} << GUARD_W;
        if (exp_y > exp_x) begin
            gap   = exp_y - exp_x;
            mag_x = (gap >= EXT_W) ? '0 : mag_x >> gap;
            exp_r = exp_y;
        end else begin
            gap   = exp_x - exp_y;
            mag_y = (gap >= EXT_W) ? '0 : mag_y >> gap;
            exp_r = exp_x;
        end
        if (sign_x == sign_y) begin
            mag    = mag_x + mag_y;
            sign_r = sign_x;
        end else if (mag_x >= mag_y) begin
            mag    = mag_x - mag_y;
            sign_r = sign_x;
        end else begin
            mag    = mag_y - mag_x;
            sign_r = sign_y;
        end
        if (mag[EXT_W]) begin
            mag   = mag >> 1;
            exp_r = exp_r + 1;
        end
        // Guard bits alone give no leading one
        if (mag[EXT_W-1:GUARD_W] == '0) begin
            return '0;
        end
        while (!mag[EXT_W-1]) begin
            mag   = mag << 1;
            exp_r = exp_r - 1;
        end
        res.sign = sign_r;
        res.exp  = EXP_W'(exp_r);
        res.frac = mag[EXT_W-2:GUARD_W];
        return res;
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic send_op(input fpu_op_e op, input fp32_t a, input fp32_t b,
                           input fp32_t expected);
        @(posedge clk);
        i_valid <= 1'b1;
        i_op    <= op;
        i_a     <= a;
        i_b     <= b;
        expected_q.push_back(expected);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        i_valid <= 1'b0;
    endtask

    initial begin
        fpu_op_e op_rand;
        fp32_t   a_rand;
        fp32_t   b_rand;
        int      wait_cycles;
        clk     = 1'b0;
        rst_n   = 1'b0;
        i_valid = 1'b0;
        i_op    = FPU_ADD;
        i_a     = '0;
        i_b     = '0;
        void'($urandom(36));
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) idle_cycle();

        // Directed table with one idle cycle after each entry
        for (int i = 0; i < NUM_VECTORS; i++) begin
            send_op(VECTORS[i].op, VECTORS[i].a, VECTORS[i].b, VECTORS[i].result);
            idle_cycle();
        end

        // Back to back random stream
        for (int i = 0; i < NUM_RANDOM; i++) begin
            op_rand     = fpu_op_e'($urandom_range(1, 0));
            a_rand.sign = $urandom_range(1, 0);
            a_rand.exp  = $urandom_range(150, 100);
            a_rand.frac = FRAC_W'($urandom());
            b_rand.sign = $urandom_range(1, 0);
            b_rand.exp  = $urandom_range(150, 100);
            b_rand.frac = FRAC_W'($urandom());
            send_op(op_rand, a_rand, b_rand, reference_addsub(op_rand, a_rand, b_rand));
        end
        idle_cycle();

        wait_cycles = 0;
        while (expected_q.size() != 0 && wait_cycles < PIPE_LAT + 4) begin
            @(posedge clk);
            wait_cycles++;
        end
        repeat (2) @(posedge clk);
        if (expected_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run($sformatf("%0d results never came out", expected_q.size()));
        end
    end

    //////////////////////////////
    // Output monitor
    //////////////////////////////
    // Output checks on the falling edge
    always @(negedge clk) begin : monitor
        fp32_t expected;
        if (!rst_n) begin
            valid_hist = '0;
            check_valid("o_valid", o_valid, 1'b0);
            check_result("o_result", o_result, '0);
        end else begin
            // Strobe driven PIPE_LAT edges ago
            check_valid("o_valid", o_valid, valid_hist[PIPE_LAT-1]);
            if (o_valid) begin
                if (expected_q.size() == 0) begin
                    abort_run("o_valid rose with no operation outstanding");
                end
                expected = expected_q.pop_front();
                check_result("o_result", o_result, expected);
                results_seen++;
            end else if (results_seen == 0) begin
                check_result("o_result", o_result, '0);
            end
            valid_hist = {valid_hist[PIPE_LAT-2:0], i_valid};
        end
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * RUN_CYCLES);
        abort_run($sformatf("run timed out with %0d results outstanding",
                            expected_q.size()));
    end

endmodule
